// File: source/dma_counters.sv
`timescale 1ns/1ps
`default_nettype none

module dma_counters #(
    parameter int DESC_CREDITS = 4
) (
    input  logic        pcie_clk,
    input  logic        pcie_reset_n,
    input  logic        sw_reset,

    input  logic        desc_valid,
    input  logic        desc_credit_return,
    input  logic        pkt_dropped,
    input  logic        head_wr_en,

    output logic        credit_avail,
    output logic [31:0] pkt_buf_full_cnt,
    output logic [31:0] rx_pkt_head_upd_cnt,
    output logic [31:0] rx_desc_cnt
);

localparam int CREDIT_WIDTH = $clog2(DESC_CREDITS + 1);
localparam int NB_STATS     = 3;

logic [CREDIT_WIDTH-1:0] credits;
logic [NB_STATS-1:0]     stat_event;
logic [31:0]             stat_cnt [NB_STATS];

// A return and a spend in the same cycle cancel out.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        credits <= CREDIT_WIDTH'(DESC_CREDITS);
    end else begin
        credits <= credits + CREDIT_WIDTH'(desc_credit_return)
                           - CREDIT_WIDTH'(desc_valid);
    end
end

assign credit_avail = credits != '0;

assign stat_event = {desc_valid, head_wr_en, pkt_dropped};

// Software can clear the statistics without touching the credits.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        for (int i = 0; i < NB_STATS; i++) begin
            stat_cnt[i] <= '0;
        end
    end else begin
        for (int i = 0; i < NB_STATS; i++) begin
            if (stat_event[i]) begin
                stat_cnt[i] <= stat_cnt[i] + 32'd1;
            end
        end
    end
end

assign pkt_buf_full_cnt    = stat_cnt[0];
assign rx_pkt_head_upd_cnt = stat_cnt[1];
assign rx_desc_cnt         = stat_cnt[2];

endmodule

`default_nettype wire

// File: source/mmio_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_decoder import pkt_dma_pkg::*; #(
    parameter int NB_QUEUES       = 16,
    parameter int QUEUE_IDX_WIDTH = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  logic                       mmio_write,
    input  logic [15:0]                mmio_address,
    input  logic [31:0]                mmio_writedata,

    output logic [RB_AWIDTH:0]         pkt_rb_size,
    output logic                       dma_disable,
    output logic                       sw_reset,

    output logic                       head_wr_en,
    output logic [QUEUE_IDX_WIDTH-1:0] head_wr_idx,
    output logic [RB_AWIDTH-1:0]       head_wr_value
);

mmio_region_t region;
logic [14:0]  addr_queue_idx;
logic         head_in_range;

assign region         = mmio_region_t'(mmio_address[15]);
assign addr_queue_idx = mmio_address[14:0];
assign head_in_range  = addr_queue_idx < NB_QUEUES;

// Only the used fields of the control register are kept.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        pkt_rb_size <= {1'b1, {RB_AWIDTH{1'b0}}};
        dma_disable <= 1'b0;
        sw_reset    <= 1'b0;
        head_wr_en  <= 1'b0;
    end else begin
        head_wr_en <= mmio_write && (region == MMIO_PKT_HEAD) && head_in_range;

        if (mmio_write && (region == MMIO_CONTROL)) begin
            dma_disable <= mmio_writedata[CTRL_DISABLE_BIT];
            pkt_rb_size <= mmio_writedata[CTRL_RB_SIZE_LSB +: RB_AWIDTH+1];
            sw_reset    <= mmio_writedata[CTRL_SW_RESET_BIT];
        end
    end
end

// Index and value only matter when head_wr_en is set.
always_ff @(posedge pcie_clk) begin
    if (mmio_write) begin
        head_wr_idx   <= addr_queue_idx[QUEUE_IDX_WIDTH-1:0];
        head_wr_value <= mmio_writedata[RB_AWIDTH-1:0];
    end
end

endmodule

`default_nettype wire

// File: source/pkt_dma_pkg.sv
`default_nettype none

package pkt_dma_pkg;

    // Ring pointers index slots, and the ring size field is one bit wider
    // so that a full 2^RB_AWIDTH ring can be expressed.
    localparam int RB_AWIDTH = 8;

    localparam int META_SIZE_WIDTH = 11;

    localparam int SLOT_BYTES = 64;
    localparam int SLOT_WIDTH = 6;

    // Control register layout.
    localparam int CTRL_DISABLE_BIT  = 0;
    localparam int CTRL_RB_SIZE_LSB  = 1;
    localparam int CTRL_SW_RESET_BIT = 27;

    // Address bit 15 selects the register region.
    typedef enum logic [0:0] {
        MMIO_CONTROL  = 1'b0,
        MMIO_PKT_HEAD = 1'b1
    } mmio_region_t;

    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,
        RX_LOOKUP = 2'd1,
        RX_ISSUE  = 2'd2
    } rx_fsm_state_t;

endpackage

`default_nettype wire

// File: source/pkt_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_dma_top import pkt_dma_pkg::*; #(
    parameter int NB_QUEUES       = 16,
    parameter int QUEUE_IDX_WIDTH = 4,
    parameter int DESC_CREDITS    = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  logic                       meta_valid,
    input  logic [QUEUE_IDX_WIDTH-1:0] meta_queue_id,
    input  logic [META_SIZE_WIDTH-1:0] meta_size,
    output logic                       meta_ready,

    output logic                       desc_valid,
    output logic [QUEUE_IDX_WIDTH-1:0] desc_queue_id,
    output logic [RB_AWIDTH-1:0]       desc_offset,
    output logic [SLOT_WIDTH-1:0]      desc_slots,
    input  logic                       desc_credit_return,

    input  logic                       mmio_write,
    input  logic [15:0]                mmio_address,
    input  logic [31:0]                mmio_writedata,

    output logic [31:0]                pkt_buf_full_cnt,
    output logic [31:0]                rx_pkt_head_upd_cnt,
    output logic [31:0]                rx_desc_cnt
);

logic [RB_AWIDTH:0]         pkt_rb_size;
logic                       dma_disable;
logic                       sw_reset;

logic                       head_wr_en;
logic [QUEUE_IDX_WIDTH-1:0] head_wr_idx;
logic [RB_AWIDTH-1:0]       head_wr_value;

logic [QUEUE_IDX_WIDTH-1:0] rd_idx;
logic [RB_AWIDTH-1:0]       rd_head;
logic [RB_AWIDTH-1:0]       rd_tail;

logic                       tail_wr_en;
logic [QUEUE_IDX_WIDTH-1:0] tail_wr_idx;
logic [RB_AWIDTH-1:0]       tail_wr_value;

logic                       pkt_dropped;
logic                       credit_avail;

mmio_decoder #(
    .NB_QUEUES       (NB_QUEUES),
    .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH)
) mmio_decoder_i (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .mmio_write     (mmio_write),
    .mmio_address   (mmio_address),
    .mmio_writedata (mmio_writedata),
    .pkt_rb_size    (pkt_rb_size),
    .dma_disable    (dma_disable),
    .sw_reset       (sw_reset),
    .head_wr_en     (head_wr_en),
    .head_wr_idx    (head_wr_idx),
    .head_wr_value  (head_wr_value)
);

pkt_queue_table #(
    .NB_QUEUES       (NB_QUEUES),
    .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH)
) pkt_queue_table_i (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .head_wr_en    (head_wr_en),
    .head_wr_idx   (head_wr_idx),
    .head_wr_value (head_wr_value),
    .rd_idx        (rd_idx),
    .tail_wr_en    (tail_wr_en),
    .tail_wr_idx   (tail_wr_idx),
    .tail_wr_value (tail_wr_value),
    .rd_head       (rd_head),
    .rd_tail       (rd_tail)
);

rx_meta_fsm #(
    .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH)
) rx_meta_fsm_i (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .meta_valid    (meta_valid),
    .meta_queue_id (meta_queue_id),
    .meta_size     (meta_size),
    .dma_disable   (dma_disable),
    .pkt_rb_size   (pkt_rb_size),
    .rd_head       (rd_head),
    .rd_tail       (rd_tail),
    .credit_avail  (credit_avail),
    .meta_ready    (meta_ready),
    .rd_idx        (rd_idx),
    .tail_wr_en    (tail_wr_en),
    .tail_wr_idx   (tail_wr_idx),
    .tail_wr_value (tail_wr_value),
    .desc_valid    (desc_valid),
    .desc_queue_id (desc_queue_id),
    .desc_offset   (desc_offset),
    .desc_slots    (desc_slots),
    .pkt_dropped   (pkt_dropped)
);

dma_counters #(
    .DESC_CREDITS (DESC_CREDITS)
) dma_counters_i (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .sw_reset            (sw_reset),
    .desc_valid          (desc_valid),
    .desc_credit_return  (desc_credit_return),
    .pkt_dropped         (pkt_dropped),
    .head_wr_en          (head_wr_en),
    .credit_avail        (credit_avail),
    .pkt_buf_full_cnt    (pkt_buf_full_cnt),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt),
    .rx_desc_cnt         (rx_desc_cnt)
);

endmodule

`default_nettype wire

// File: source/pkt_queue_table.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_queue_table import pkt_dma_pkg::*; #(
    parameter int NB_QUEUES       = 16,
    parameter int QUEUE_IDX_WIDTH = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  logic                       head_wr_en,
    input  logic [QUEUE_IDX_WIDTH-1:0] head_wr_idx,
    input  logic [RB_AWIDTH-1:0]       head_wr_value,

    input  logic [QUEUE_IDX_WIDTH-1:0] rd_idx,

    input  logic                       tail_wr_en,
    input  logic [QUEUE_IDX_WIDTH-1:0] tail_wr_idx,
    input  logic [RB_AWIDTH-1:0]       tail_wr_value,

    output logic [RB_AWIDTH-1:0]       rd_head,
    output logic [RB_AWIDTH-1:0]       rd_tail
);

logic [RB_AWIDTH-1:0] heads [NB_QUEUES];
logic [RB_AWIDTH-1:0] tails [NB_QUEUES];

// Heads come from software, tails from the receive FSM.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        for (int i = 0; i < NB_QUEUES; i++) begin
            heads[i] <= '0;
            tails[i] <= '0;
        end
    end else begin
        if (head_wr_en && (head_wr_idx < NB_QUEUES)) begin
            heads[head_wr_idx] <= head_wr_value;
        end
        if (tail_wr_en && (tail_wr_idx < NB_QUEUES)) begin
            tails[tail_wr_idx] <= tail_wr_value;
        end
    end
end

// The read sees the table as it was before this edge's writes.
always_ff @(posedge pcie_clk) begin
    if (rd_idx < NB_QUEUES) begin
        rd_head <= heads[rd_idx];
        rd_tail <= tails[rd_idx];
    end else begin
        rd_head <= '0;
        rd_tail <= '0;
    end
end

endmodule

`default_nettype wire

// File: source/rx_meta_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rx_meta_fsm import pkt_dma_pkg::*; #(
    parameter int QUEUE_IDX_WIDTH = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  logic                       meta_valid,
    input  logic [QUEUE_IDX_WIDTH-1:0] meta_queue_id,
    input  logic [META_SIZE_WIDTH-1:0] meta_size,

    input  logic                       dma_disable,
    input  logic [RB_AWIDTH:0]         pkt_rb_size,

    input  logic [RB_AWIDTH-1:0]       rd_head,
    input  logic [RB_AWIDTH-1:0]       rd_tail,
    input  logic                       credit_avail,

    output logic                       meta_ready,
    output logic [QUEUE_IDX_WIDTH-1:0] rd_idx,

    output logic                       tail_wr_en,
    output logic [QUEUE_IDX_WIDTH-1:0] tail_wr_idx,
    output logic [RB_AWIDTH-1:0]       tail_wr_value,

    output logic                       desc_valid,
    output logic [QUEUE_IDX_WIDTH-1:0] desc_queue_id,
    output logic [RB_AWIDTH-1:0]       desc_offset,
    output logic [SLOT_WIDTH-1:0]      desc_slots,

    output logic                       pkt_dropped
);

localparam int SLOT_SHIFT = $clog2(SLOT_BYTES);

rx_fsm_state_t state;

logic [QUEUE_IDX_WIDTH-1:0] queue_id_r;
logic [SLOT_WIDTH-1:0]      slots_r;
logic [RB_AWIDTH-1:0]       offset_r;
logic [RB_AWIDTH-1:0]       tail_next_r;

logic [META_SIZE_WIDTH:0]   size_round;
logic [SLOT_WIDTH-1:0]      meta_slots;
logic [RB_AWIDTH-1:0]       rb_mask;
logic [RB_AWIDTH-1:0]       used_slots;
logic [RB_AWIDTH:0]         free_slots;
logic                       fits;
logic                       accept;

// Round the byte count up to whole slots; an empty packet still takes one.
assign size_round = {1'b0, meta_size} + (META_SIZE_WIDTH+1)'(SLOT_BYTES - 1);
assign meta_slots = (meta_size == '0) ? SLOT_WIDTH'(1)
                                      : size_round[SLOT_SHIFT +: SLOT_WIDTH];

// The ring size is a power of two, so wrapping is a mask.
assign rb_mask    = RB_AWIDTH'(pkt_rb_size - 1'b1);
assign used_slots = (rd_tail - rd_head) & rb_mask;
assign free_slots = pkt_rb_size - 1'b1 - {1'b0, used_slots};
assign fits       = (RB_AWIDTH+1)'(slots_r) <= free_slots;

assign meta_ready = (state == RX_IDLE) && !dma_disable;
assign accept     = meta_valid && meta_ready;

// The table read is issued in the accept cycle and lands in RX_LOOKUP.
assign rd_idx = (state == RX_IDLE) ? meta_queue_id : queue_id_r;

assign pkt_dropped = (state == RX_LOOKUP) && !fits;
assign desc_valid  = (state == RX_ISSUE) && credit_avail;

assign desc_queue_id = queue_id_r;
assign desc_offset   = offset_r;
assign desc_slots    = slots_r;

// The tail moves forward in the same cycle the descriptor goes out.
assign tail_wr_en    = desc_valid;
assign tail_wr_idx   = queue_id_r;
assign tail_wr_value = tail_next_r;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        state <= RX_IDLE;
    end else begin
        case (state)
            RX_IDLE: begin
                if (accept) begin
                    state <= RX_LOOKUP;
                end
            end
            RX_LOOKUP: begin
                state <= fits ? RX_ISSUE : RX_IDLE;
            end
            RX_ISSUE: begin
                if (credit_avail) begin
                    state <= RX_IDLE;
                end
            end
            default: begin
                state <= RX_IDLE;
            end
        endcase
    end
end

always_ff @(posedge pcie_clk) begin
    if (accept) begin
        queue_id_r <= meta_queue_id;
        slots_r    <= meta_slots;
    end
    if (state == RX_LOOKUP) begin
        offset_r    <= rd_tail;
        tail_next_r <= (rd_tail + RB_AWIDTH'(slots_r)) & rb_mask;
    end
end

endmodule

`default_nettype wire

// File: tb.f
source/pkt_dma_pkg.sv
source/mmio_decoder.sv
source/pkt_queue_table.sv
source/rx_meta_fsm.sv
source/dma_counters.sv
source/pkt_dma_top.sv
verif/tb_clock_gen.sv
verif/pkt_dma_tb.sv

// File: verif/pkt_dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_dma_tb import pkt_dma_pkg::*;;

localparam int          NB_QUEUES       = 16;
localparam int          QUEUE_IDX_WIDTH = 4;
localparam int          DESC_CREDITS    = 4;
localparam int          CLK_PERIOD      = 20;
localparam int          RESET_CYCLES    = 8;
localparam int          NUM_TXN         = 400;
localparam logic [31:0] SEED            = 32'h92e8_a4e9;
localparam longint      TIMEOUT_NS      = longint'(NUM_TXN * 40 + RESET_CYCLES) * CLK_PERIOD;

logic                       pcie_clk;
logic                       pcie_reset_n;
logic                       meta_valid;
logic [QUEUE_IDX_WIDTH-1:0] meta_queue_id;
logic [META_SIZE_WIDTH-1:0] meta_size;
logic                       meta_ready;
logic                       desc_valid;
logic [QUEUE_IDX_WIDTH-1:0] desc_queue_id;
logic [RB_AWIDTH-1:0]       desc_offset;
logic [SLOT_WIDTH-1:0]      desc_slots;
logic                       desc_credit_return;
logic                       mmio_write;
logic [15:0]                mmio_address;
logic [31:0]                mmio_writedata;
logic [31:0]                pkt_buf_full_cnt;
logic [31:0]                rx_pkt_head_upd_cnt;
logic [31:0]                rx_desc_cnt;

// Reference model state, updated at each rising edge.
rx_fsm_state_t m_phase = RX_IDLE;
int   m_head [NB_QUEUES];
int   m_tail [NB_QUEUES];
int   m_credits = DESC_CREDITS;
int   m_rb_size = 1 << RB_AWIDTH;
logic m_disable = 1'b0;
logic m_sw_reset = 1'b0;
int   m_full_cnt, m_head_cnt, m_desc_cnt;
logic m_fit;
int   m_exp_queue, m_exp_offset, m_exp_slots, m_exp_next;
logic hw_pend = 1'b0;
int   hw_idx, hw_value;
int   total_issued = 0;
int   total_dropped = 0;
logic last_accept = 1'b0;
logic withhold;
logic exp_ready, exp_valid, accept_now, drop_now;
int   txn, pick;

tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
) clock_gen_i (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n)
);

pkt_dma_top #(
    .NB_QUEUES       (NB_QUEUES),
    .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH),
    .DESC_CREDITS    (DESC_CREDITS)
) pkt_dma_top_i (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .meta_valid          (meta_valid),
    .meta_queue_id       (meta_queue_id),
    .meta_size           (meta_size),
    .meta_ready          (meta_ready),
    .desc_valid          (desc_valid),
    .desc_queue_id       (desc_queue_id),
    .desc_offset         (desc_offset),
    .desc_slots          (desc_slots),
    .desc_credit_return  (desc_credit_return),
    .mmio_write          (mmio_write),
    .mmio_address        (mmio_address),
    .mmio_writedata      (mmio_writedata),
    .pkt_buf_full_cnt    (pkt_buf_full_cnt),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt),
    .rx_desc_cnt         (rx_desc_cnt)
);

task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
    abort_run();
endtask

task automatic report_error(input string what);
    $display("ERROR: %s", what);
    abort_run();
endtask

task automatic reset_model();
    for (int i = 0; i < NB_QUEUES; i++) begin
        m_head[i] = 0;
        m_tail[i] = 0;
    end
    m_phase     = RX_IDLE;
    m_credits   = DESC_CREDITS;
    m_rb_size   = 1 << RB_AWIDTH;
    m_disable   = 1'b0;
    m_sw_reset  = 1'b0;
    m_full_cnt  = 0;
    m_head_cnt  = 0;
    m_desc_cnt  = 0;
    hw_pend     = 1'b0;
    last_accept = 1'b0;
endtask

// Slots round up to 64 bytes and one slot always stays free.
function automatic void decide_packet(input int q, input int size);
    int slots;
    int used;
    int free_space;
    slots        = (size == 0) ? 1 : (size + SLOT_BYTES - 1) / SLOT_BYTES;
    used         = (m_tail[q] - m_head[q] + (1 << RB_AWIDTH)) % m_rb_size;
    free_space   = m_rb_size - 1 - used;
    m_fit        = slots <= free_space;
    m_exp_queue  = q;
    m_exp_offset = m_tail[q];
    m_exp_slots  = slots;
    m_exp_next   = (m_tail[q] + slots) % m_rb_size;
endfunction

always @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        reset_model();
    end else begin
        exp_ready = (m_phase == RX_IDLE) && !m_disable;
        exp_valid = (m_phase == RX_ISSUE) && (m_credits > 0);
        assert (meta_ready === exp_ready)
            else report_mismatch("meta_ready", 32'(meta_ready), 32'(exp_ready));
        assert (desc_valid === exp_valid)
            else report_mismatch("desc_valid", 32'(desc_valid), 32'(exp_valid));
        if (exp_valid) begin
            assert (desc_queue_id === m_exp_queue)
                else report_mismatch("desc_queue_id", 32'(desc_queue_id), m_exp_queue);
            assert (desc_offset === m_exp_offset)
                else report_mismatch("desc_offset", 32'(desc_offset), m_exp_offset);
            assert (desc_slots === m_exp_slots)
                else report_mismatch("desc_slots", 32'(desc_slots), m_exp_slots);
        end
        assert (pkt_buf_full_cnt === m_full_cnt)
            else report_mismatch("pkt_buf_full_cnt", pkt_buf_full_cnt, m_full_cnt);
        assert (rx_pkt_head_upd_cnt === m_head_cnt)
            else report_mismatch("rx_pkt_head_upd_cnt", rx_pkt_head_upd_cnt, m_head_cnt);
        assert (rx_desc_cnt === m_desc_cnt)
            else report_mismatch("rx_desc_cnt", rx_desc_cnt, m_desc_cnt);

        accept_now = meta_valid && exp_ready;
        drop_now   = (m_phase == RX_LOOKUP) && !m_fit;
        if (m_sw_reset) begin
            m_full_cnt = 0;
            m_head_cnt = 0;
            m_desc_cnt = 0;
        end else begin
            m_full_cnt += drop_now;
            m_head_cnt += hw_pend;
            m_desc_cnt += exp_valid;
        end
        total_dropped += drop_now;
        total_issued  += exp_valid;
        if (desc_credit_return) m_credits++;
        if (exp_valid) m_credits--;

        case (m_phase)
            RX_IDLE: begin
                if (accept_now) begin
                    decide_packet(meta_queue_id, meta_size);
                    m_phase = RX_LOOKUP;
                end
            end
            RX_LOOKUP: begin
                m_phase = m_fit ? RX_ISSUE : RX_IDLE;
            end
            RX_ISSUE: begin
                if (exp_valid) begin
                    m_tail[m_exp_queue] = m_exp_next;
                    m_phase = RX_IDLE;
                end
            end
            default: begin
                m_phase = RX_IDLE;
            end
        endcase

        // The lookup above sampled the heads before this edge's table write.
        if (hw_pend) m_head[hw_idx] = hw_value;
        hw_pend  = mmio_write && mmio_address[15] && (mmio_address[14:0] < NB_QUEUES);
        hw_idx   = mmio_address[QUEUE_IDX_WIDTH-1:0];
        hw_value = mmio_writedata[RB_AWIDTH-1:0];
        if (mmio_write && !mmio_address[15]) begin
            m_disable  = mmio_writedata[CTRL_DISABLE_BIT];
            m_rb_size  = mmio_writedata[CTRL_RB_SIZE_LSB +: RB_AWIDTH+1];
            m_sw_reset = mmio_writedata[CTRL_SW_RESET_BIT];
        end
        last_accept = accept_now;
    end
end

task automatic wait_idle();
    @(negedge pcie_clk);
    meta_valid = 1'b0;
    mmio_write = 1'b0;
    while (m_phase != RX_IDLE) @(negedge pcie_clk);
endtask

task automatic write_control(input logic dis, input int rb_size, input logic clr);
    logic [31:0] data;
    wait_idle();
    data                               = $urandom;
    data[CTRL_DISABLE_BIT]             = dis;
    data[CTRL_RB_SIZE_LSB +: RB_AWIDTH+1] = (RB_AWIDTH+1)'(rb_size);
    data[CTRL_SW_RESET_BIT]            = clr;
    mmio_write     = 1'b1;
    mmio_address   = {1'b0, 15'($urandom)};
    mmio_writedata = data;
    @(posedge pcie_clk);
endtask

task automatic send_meta();
    @(negedge pcie_clk);
    mmio_write    = 1'b0;
    meta_valid    = 1'b1;
    meta_queue_id = QUEUE_IDX_WIDTH'($urandom % NB_QUEUES);
    meta_size     = META_SIZE_WIDTH'($urandom % 2048);
    @(posedge pcie_clk);
    while (!meta_ready) @(posedge pcie_clk);
endtask

task automatic write_head();
    int idx;
    @(negedge pcie_clk);
    meta_valid = 1'b0;
    if (($urandom % 4) == 0) begin
        idx = NB_QUEUES + ($urandom % (32768 - NB_QUEUES));
    end else begin
        idx = $urandom % NB_QUEUES;
    end
    mmio_write                         = 1'b1;
    mmio_address                       = {1'b1, 15'(idx)};
    mmio_writedata                     = $urandom;
    mmio_writedata[RB_AWIDTH-1:0]      = RB_AWIDTH'($urandom % m_rb_size);
    @(posedge pcie_clk);
endtask

// Packets keep arriving while the consumer sits on its credits.
task automatic hold_credits();
    withhold = 1'b1;
    repeat (30) begin
        @(negedge pcie_clk);
        mmio_write = 1'b0;
        if (!meta_valid || last_accept) begin
            meta_queue_id = QUEUE_IDX_WIDTH'($urandom % NB_QUEUES);
            meta_size     = META_SIZE_WIDTH'($urandom % 2048);
        end
        meta_valid = 1'b1;
    end
    @(posedge pcie_clk);
    withhold = 1'b0;
endtask

task automatic pulse_disable();
    write_control(1'b1, m_rb_size, 1'b0);
    @(negedge pcie_clk);
    mmio_write    = 1'b0;
    meta_valid    = 1'b1;
    meta_queue_id = QUEUE_IDX_WIDTH'($urandom % NB_QUEUES);
    meta_size     = META_SIZE_WIDTH'($urandom % 2048);
    repeat (12) @(posedge pcie_clk);
    write_control(1'b0, m_rb_size, 1'b0);
endtask

task automatic clear_stats();
    write_control(1'b0, m_rb_size, 1'b1);
    @(posedge pcie_clk);
    @(negedge pcie_clk);
    mmio_write = 1'b0;
    assert (pkt_buf_full_cnt === 32'd0)
        else report_mismatch("pkt_buf_full_cnt", pkt_buf_full_cnt, 32'd0);
    assert (rx_pkt_head_upd_cnt === 32'd0)
        else report_mismatch("rx_pkt_head_upd_cnt", rx_pkt_head_upd_cnt, 32'd0);
    assert (rx_desc_cnt === 32'd0)
        else report_mismatch("rx_desc_cnt", rx_desc_cnt, 32'd0);
    write_control(1'b0, m_rb_size, 1'b0);
endtask

task automatic change_ring_size();
    write_control(1'b0, 1 << (4 + ($urandom % 5)), 1'b0);
endtask

// Descriptor consumer with a random return delay.
initial begin
    desc_credit_return = 1'b0;
    forever begin
        @(negedge pcie_clk);
        desc_credit_return = !withhold && (m_credits < DESC_CREDITS)
                             && (($urandom % 3) == 0);
    end
end

initial begin
    #(TIMEOUT_NS);
    report_error("watchdog timeout, the test did not complete in time");
end

initial begin
    void'($urandom(SEED));
    meta_valid     = 1'b0;
    meta_queue_id  = '0;
    meta_size      = '0;
    mmio_write     = 1'b0;
    mmio_address   = '0;
    mmio_writedata = '0;
    withhold       = 1'b0;
    wait (pcie_reset_n === 1'b1);
    @(posedge pcie_clk);

    for (txn = 0; txn < NUM_TXN; txn++) begin
        pick = $urandom % 100;
        if (pick < 55) begin
            send_meta();
        end else if (pick < 80) begin
            write_head();
        end else if (pick < 88) begin
            hold_credits();
        end else if (pick < 93) begin
            pulse_disable();
        end else if (pick < 97) begin
            clear_stats();
        end else begin
            change_ring_size();
        end
    end

    wait_idle();
    while (m_credits != DESC_CREDITS) @(negedge pcie_clk);
    assert (total_issued > 0) else report_error("no descriptor was issued during the run");
    assert (total_dropped > 0) else report_error("no packet was dropped during the run");
    $display("RESULT: PASS");
    $finish;
end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic pcie_clk,
    output logic pcie_reset_n
);

initial begin
    pcie_clk = 1'b0;
    forever #(PERIOD_NS / 2) pcie_clk = ~pcie_clk;
end

// Reset is released on a falling edge, away from the sampling edge.
initial begin
    pcie_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge pcie_clk);
    @(negedge pcie_clk);
    pcie_reset_n = 1'b1;
end

endmodule

`default_nettype wire
